// File: Makefile
# Verilator simulation of perm_blk

TOP = perm_blk_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir -o Vsim
	./obj_dir/Vsim

clean:
	rm -rf obj_dir

// File: sim.f
+incdir+src
+incdir+test
src/keccak_pkg.sv
src/lane_loader.sv
src/round_const_gen.sv
src/keccak_round.sv
src/perm_core.sv
src/lane_unloader.sv
src/perm_blk.sv
test/tb_clock.sv
test/perm_blk_tb.sv

// File: src/keccak_cfg.svh
// Keccak-f[1600] sizes

`ifndef KECCAK_CFG_SVH
`define KECCAK_CFG_SVH

// bits per lane, one 64-bit word
`define KECCAK_LANE_W 64

// side of the 5x5 lane plane
`define KECCAK_DIM 5

// lanes in one full state
`define KECCAK_LANES 25

// rounds in one permutation
`define KECCAK_ROUNDS 24

`endif

// File: src/keccak_pkg.sv
// Keccak shared types

`include "keccak_cfg.svh"

package keccak_pkg;

	// one lane of the state
	typedef logic [`KECCAK_LANE_W-1:0] lane_t;

	// x or y coordinate, 0 to 4
	typedef logic [2:0] coord_t;

	// linear lane number, x fastest, 0 to 24
	typedef logic [4:0] lane_idx_t;

	// full 1600-bit state, outer index y, inner index x
	typedef lane_t [`KECCAK_DIM-1:0][`KECCAK_DIM-1:0] state_t;

	// one stream beat, same layout on input and output
	typedef struct packed {
		logic  first;
		lane_t data;
	} lane_beat_t;

	// round counter
	typedef logic [4:0] round_idx_t;

	// permutation core states
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_ROUND,
		CORE_HOLD
	} core_state_e;

	// rho rotate amounts, outer index x, inner index y
	localparam logic [5:0] rho_offset [`KECCAK_DIM][`KECCAK_DIM] = '{
		'{6'd0,  6'd36, 6'd3,  6'd41, 6'd18},
		'{6'd1,  6'd44, 6'd10, 6'd45, 6'd2},
		'{6'd62, 6'd6,  6'd43, 6'd15, 6'd61},
		'{6'd28, 6'd55, 6'd25, 6'd21, 6'd56},
		'{6'd27, 6'd20, 6'd39, 6'd8,  6'd14}
	};

endpackage

// File: src/keccak_round.sv
// Keccak single round

`timescale 1ns/1ps
`include "keccak_cfg.svh"

module keccak_round (
	input  keccak_pkg::state_t state_in,
	input  keccak_pkg::lane_t  rc,
	output keccak_pkg::state_t state_out
);
	import keccak_pkg::*;

	lane_t [`KECCAK_DIM-1:0] col_par;
	lane_t [`KECCAK_DIM-1:0] col_mix;
	state_t                  theta_s;
	state_t                  pi_s;
	state_t                  chi_s;

	// rotate left, n of 0 leaves the lane as is
	function automatic lane_t rotl(input lane_t v, input logic [5:0] n);
		return (v << n) | (v >> (`KECCAK_LANE_W - n));
	endfunction

	// theta, parity of every column
	always_comb begin
		for (int x = 0; x < `KECCAK_DIM; x++) begin
			col_par[x] = '0;
			for (int y = 0; y < `KECCAK_DIM; y++) begin
				col_par[x] = col_par[x] ^ state_in[y][x];
			end
		end
	end

	// theta, mix left column parity with rotated right column parity
	always_comb begin
		for (int x = 0; x < `KECCAK_DIM; x++) begin
			col_mix[x] = col_par[(x + `KECCAK_DIM - 1) % `KECCAK_DIM]
				^ rotl(col_par[(x + 1) % `KECCAK_DIM], 6'd1);
		end
	end

	always_comb begin
		for (int y = 0; y < `KECCAK_DIM; y++) begin
			for (int x = 0; x < `KECCAK_DIM; x++) begin
				theta_s[y][x] = state_in[y][x] ^ col_mix[x];
			end
		end
	end

	// rho and pi together
	// lane (x,y) rotated by its offset, then moved to (y, 2x+3y)
	always_comb begin
		for (int y = 0; y < `KECCAK_DIM; y++) begin
			for (int x = 0; x < `KECCAK_DIM; x++) begin
				pi_s[(2 * x + 3 * y) % `KECCAK_DIM][y] =
					rotl(theta_s[y][x], rho_offset[x][y]);
			end
		end
	end

	// chi, nonlinear step within each row
	always_comb begin
		for (int y = 0; y < `KECCAK_DIM; y++) begin
			for (int x = 0; x < `KECCAK_DIM; x++) begin
				chi_s[y][x] = pi_s[y][x]
					^ (~pi_s[y][(x + 1) % `KECCAK_DIM]
					& pi_s[y][(x + 2) % `KECCAK_DIM]);
			end
		end
	end

	// iota, round constant only touches lane (0,0)
	always_comb begin
		state_out       = chi_s;
		state_out[0][0] = chi_s[0][0] ^ rc;
	end

endmodule

// File: src/lane_loader.sv
// Input lane collector

`timescale 1ns/1ps
`include "keccak_cfg.svh"

module lane_loader (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pushin,
	input  keccak_pkg::lane_beat_t in_beat,
	output logic                  stopin,
	output logic                  block_valid,
	output keccak_pkg::state_t    block,
	input  logic                  block_take
);
	import keccak_pkg::*;

	state_t    blk_buf;
	lane_idx_t cnt;
	coord_t    wr_x;
	coord_t    wr_y;
	coord_t    wx;
	coord_t    wy;
	logic      accept;
	logic      store;

	// refuse beats only while a complete block waits for the core
	assign stopin = block_valid;
	assign accept = pushin & ~stopin;
	// empty loader ignores anything but a first beat
	assign store = accept & (in_beat.first | (cnt != '0));

	// a first beat always lands in lane (0,0)
	assign wx = in_beat.first ? coord_t'(0) : wr_x;
	assign wy = in_beat.first ? coord_t'(0) : wr_y;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt         <= '0;
			wr_x        <= '0;
			wr_y        <= '0;
			block_valid <= 1'b0;
		end else if (block_take) begin
			// core grabbed the block, ready for the next one
			block_valid <= 1'b0;
		end else if (store) begin
			if (in_beat.first) begin
				// start or restart, lane 0 is now stored
				cnt  <= lane_idx_t'(1);
				wr_x <= coord_t'(1);
				wr_y <= '0;
			end else if (cnt == lane_idx_t'(`KECCAK_LANES - 1)) begin
				// 25th lane, block complete
				cnt         <= '0;
				wr_x        <= '0;
				wr_y        <= '0;
				block_valid <= 1'b1;
			end else begin
				cnt <= cnt + lane_idx_t'(1);
				// x runs fastest, wrap into the next row
				if (wr_x == coord_t'(`KECCAK_DIM - 1)) begin
					wr_x <= '0;
					wr_y <= wr_y + coord_t'(1);
				end else begin
					wr_x <= wr_x + coord_t'(1);
				end
			end
		end
	end

	// lane storage
	always_ff @(posedge clk) begin
		if (store) begin
			blk_buf[wy][wx] <= in_beat.data;
		end
	end

	assign block = blk_buf;

endmodule

// File: src/lane_unloader.sv
// Result lane streamer

`timescale 1ns/1ps
`include "keccak_cfg.svh"

module lane_unloader (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   result_valid,
	input  keccak_pkg::state_t     result,
	output logic                   result_take,
	output logic                   pushout,
	output keccak_pkg::lane_beat_t out_beat,
	input  logic                   stopout
);
	import keccak_pkg::*;

	state_t snap;
	coord_t rd_x;
	coord_t rd_y;
	logic   busy;
	logic   advance;
	logic   last_lane;

	// grab a finished result only when the previous one is fully sent
	assign result_take = result_valid & ~busy;
	assign pushout     = busy;
	// a beat moves on every edge with stopout low
	assign advance     = busy & ~stopout;
	assign last_lane   = (rd_x == coord_t'(`KECCAK_DIM - 1))
		&& (rd_y == coord_t'(`KECCAK_DIM - 1));

	// beat is a pure function of snapshot and read pointer
	// so it stays put while stalled
	assign out_beat.first = busy && (rd_x == '0) && (rd_y == '0);
	assign out_beat.data  = busy ? snap[rd_y][rd_x] : '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			rd_x <= '0;
			rd_y <= '0;
		end else if (result_take) begin
			busy <= 1'b1;
			rd_x <= '0;
			rd_y <= '0;
		end else if (advance) begin
			if (last_lane) begin
				// lane 24 gone, empty again
				busy <= 1'b0;
				rd_x <= '0;
				rd_y <= '0;
			end else if (rd_x == coord_t'(`KECCAK_DIM - 1)) begin
				rd_x <= '0;
				rd_y <= rd_y + coord_t'(1);
			end else begin
				rd_x <= rd_x + coord_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (result_take) begin
			snap <= result;
		end
	end

endmodule

// File: src/perm_blk.sv
// Keccak-f[1600] permutation block

`timescale 1ns/1ps

module perm_blk (
	input  logic              clk,
	input  logic              rst,
	input  logic              pushin,
	input  logic              firstin,
	input  keccak_pkg::lane_t din,
	output logic              stopin,
	output logic              pushout,
	output logic              firstout,
	output keccak_pkg::lane_t dout,
	input  logic              stopout
);
	import keccak_pkg::*;

	lane_beat_t in_beat;
	lane_beat_t out_beat;
	state_t     block;
	state_t     result;
	logic       block_valid;
	logic       block_take;
	logic       result_valid;
	logic       result_take;

	// pack the input pins into one beat
	assign in_beat = '{first: firstin, data: din};

	lane_loader u_loader (
		.clk         (clk),
		.rst         (rst),
		.pushin      (pushin),
		.in_beat     (in_beat),
		.stopin      (stopin),
		.block_valid (block_valid),
		.block       (block),
		.block_take  (block_take)
	);

	perm_core u_core (
		.clk          (clk),
		.rst          (rst),
		.block_valid  (block_valid),
		.block        (block),
		.block_take   (block_take),
		.result_valid (result_valid),
		.result       (result),
		.result_take  (result_take)
	);

	lane_unloader u_unloader (
		.clk          (clk),
		.rst          (rst),
		.result_valid (result_valid),
		.result       (result),
		.result_take  (result_take),
		.pushout      (pushout),
		.out_beat     (out_beat),
		.stopout      (stopout)
	);

	// split the output beat back onto the pins
	assign firstout = out_beat.first;
	assign dout     = out_beat.data;

endmodule

// File: src/perm_core.sv
// Permutation round sequencer

`timescale 1ns/1ps

module perm_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               block_valid,
	input  keccak_pkg::state_t block,
	output logic               block_take,
	output logic               result_valid,
	output keccak_pkg::state_t result,
	input  logic               result_take
);
	import keccak_pkg::*;

	core_state_e st;
	core_state_e st_next;
	state_t      work;
	state_t      round_out;
	lane_t       rc;
	logic        last_round;
	logic        round_step;

	// take the waiting block whenever idle
	assign block_take   = (st == CORE_IDLE) && block_valid;
	assign round_step   = (st == CORE_ROUND);
	assign result_valid = (st == CORE_HOLD);
	assign result       = work;

	round_const_gen u_rc_gen (
		.clk        (clk),
		.rst        (rst),
		.start      (block_take),
		.step       (round_step),
		.rc         (rc),
		.last_round (last_round)
	);

	// one full round per clock
	keccak_round u_round (
		.state_in  (work),
		.rc        (rc),
		.state_out (round_out)
	);

	always_comb begin
		st_next = st;
		case (st)
			CORE_IDLE: begin
				if (block_valid) begin
					st_next = CORE_ROUND;
				end
			end
			CORE_ROUND: begin
				// round 23 is being applied this cycle
				if (last_round) begin
					st_next = CORE_HOLD;
				end
			end
			CORE_HOLD: begin
				// wait for the unloader to snapshot the result
				if (result_take) begin
					st_next = CORE_IDLE;
				end
			end
			default: begin
				st_next = CORE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			st <= CORE_IDLE;
		end else begin
			st <= st_next;
		end
	end

	// working state, loaded on take and updated every round
	always_ff @(posedge clk) begin
		if (block_take) begin
			work <= block;
		end else if (round_step) begin
			work <= round_out;
		end
	end

endmodule

// File: src/round_const_gen.sv
// Iota round constant generator

`timescale 1ns/1ps
`include "keccak_cfg.svh"

module round_const_gen (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              step,
	output keccak_pkg::lane_t rc,
	output logic              last_round
);
	import keccak_pkg::*;

	round_idx_t rnd;
	logic [7:0] lfsr;
	logic [7:0] lfsr_next;

	// one shift of the rc LFSR, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] v);
		return {v[6:0], 1'b0} ^ (v[7] ? 8'h71 : 8'h00);
	endfunction

	// seven LFSR outputs per round go to bits 2^j - 1
	// walk ends on the seed for the following round
	always_comb begin
		rc        = '0;
		lfsr_next = lfsr;
		for (int j = 0; j < 7; j++) begin
			rc[(1 << j) - 1] = lfsr_next[0];
			lfsr_next        = lfsr_step(lfsr_next);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rnd  <= '0;
			lfsr <= 8'h01;
		end else if (start) begin
			// new permutation, back to round 0 and the seed
			rnd  <= '0;
			lfsr <= 8'h01;
		end else if (step) begin
			rnd  <= rnd + round_idx_t'(1);
			lfsr <= lfsr_next;
		end
	end

	assign last_round = (rnd == round_idx_t'(`KECCAK_ROUNDS - 1));

endmodule

// File: test/keccak_ref_model.svh
// Reference Keccak-f[1600] model

`ifndef KECCAK_REF_MODEL_SVH
`define KECCAK_REF_MODEL_SVH

// rotate left through a doubled copy of the lane
function automatic lane_t ref_rotl(input lane_t v, input int n);
	logic [2*`KECCAK_LANE_W-1:0] dbl;
	dbl = {v, v} << n;
	return dbl[2*`KECCAK_LANE_W-1:`KECCAK_LANE_W];
endfunction

// bit t of the rc stream, 9-bit register form of the spec
function automatic logic ref_rc_bit(input int t);
	logic [8:0] r;
	int i;
	r = 9'h001;
	for (i = 0; i < t % 255; i++) begin
		r = {r[7:0], 1'b0};
		r[0] = r[0] ^ r[8];
		r[4] = r[4] ^ r[8];
		r[5] = r[5] ^ r[8];
		r[6] = r[6] ^ r[8];
		r[8] = 1'b0;
	end
	return r[0];
endfunction

// iota constant of round ir
function automatic lane_t ref_round_const(input int ir);
	lane_t c;
	int j;
	c = '0;
	for (j = 0; j <= 6; j++) begin
		c[(1 << j) - 1] = ref_rc_bit(j + 7 * ir);
	end
	return c;
endfunction

// full permutation over a state indexed [y][x]
function automatic state_t ref_permute(input state_t s);
	state_t a;
	state_t b;
	lane_t  c [5];
	lane_t  d [5];
	int     off [5][5];
	int     x;
	int     y;
	int     t;
	int     tmp;
	int     r;
	a = s;
	// offsets from the walk that starts at (1,0)
	off[0][0] = 0;
	x = 1;
	y = 0;
	for (t = 0; t < 24; t++) begin
		off[x][y] = ((t + 1) * (t + 2) / 2) % 64;
		tmp = y;
		y = (2 * x + 3 * y) % 5;
		x = tmp;
	end
	for (r = 0; r < `KECCAK_ROUNDS; r++) begin
		for (x = 0; x < 5; x++) begin
			c[x] = a[0][x] ^ a[1][x] ^ a[2][x] ^ a[3][x] ^ a[4][x];
		end
		for (x = 0; x < 5; x++) begin
			d[x] = c[(x + 4) % 5] ^ ref_rotl(c[(x + 1) % 5], 1);
		end
		for (y = 0; y < 5; y++) begin
			for (x = 0; x < 5; x++) begin
				a[y][x] = a[y][x] ^ d[x];
			end
		end
		// rho then pi, (x,y) lands on (y, 2x+3y)
		for (y = 0; y < 5; y++) begin
			for (x = 0; x < 5; x++) begin
				b[(2 * x + 3 * y) % 5][y] = ref_rotl(a[y][x], off[x][y]);
			end
		end
		for (y = 0; y < 5; y++) begin
			for (x = 0; x < 5; x++) begin
				a[y][x] = b[y][x] ^ (~b[y][(x + 1) % 5] & b[y][(x + 2) % 5]);
			end
		end
		a[0][0] = a[0][0] ^ ref_round_const(r);
	end
	return a;
endfunction

`endif

// File: test/perm_blk_tb.sv
// Permutation block testbench

`timescale 1ns/1ps
`include "keccak_cfg.svh"

module perm_blk_tb;
	import keccak_pkg::*;

	`include "keccak_ref_model.svh"

	localparam int STOPIN_LIMIT = 2000;
	localparam int DRAIN_LIMIT  = 20000;

	logic   clk;
	logic   rst;
	logic   pushin;
	logic   firstin;
	lane_t  din;
	logic   stopin;
	logic   pushout;
	logic   firstout;
	lane_t  dout;
	logic   stopout;

	// scoreboard of expected results with the oldest at the front
	state_t exp_q [$];
	state_t coll;
	state_t cur;
	int     coll_cnt;
	int     out_pos;
	int     stall_pct;
	int     gap_pct;
	logic   held;
	lane_t  held_data;
	logic   held_first;
	lane_t  last_lane0;

	tb_clock u_clk (
		.clk (clk)
	);

	perm_blk uut (
		.clk      (clk),
		.rst      (rst),
		.pushin   (pushin),
		.firstin  (firstin),
		.din      (din),
		.stopin   (stopin),
		.pushout  (pushout),
		.firstout (firstout),
		.dout     (dout),
		.stopout  (stopout)
	);

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic fail_run(input string why);
		$display("error at %0t: %s", $time, why);
		abort_run();
	endtask

	task automatic check_lane(input string name, input lane_t got, input lane_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_first(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic lane_t rand_lane();
		return {$urandom, $urandom};
	endfunction

	// builds the expected block by the loader rules seen from outside
	// full reports that this beat completed a block
	task automatic model_accept(input logic first, input lane_t data, output logic full);
		full = 1'b0;
		if (first) begin
			coll[0][0] = data;
			coll_cnt = 1;
		end else if (coll_cnt != 0) begin
			coll[coll_cnt / 5][coll_cnt % 5] = data;
			coll_cnt++;
			if (coll_cnt == `KECCAK_LANES) begin
				exp_q.push_back(ref_permute(coll));
				coll_cnt = 0;
				full = 1'b1;
			end
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic send_beat(input logic first, input lane_t data);
		int   gaps;
		int   waited;
		logic full;
		gaps = 0;
		if (gap_pct > 0 && $urandom_range(99) < gap_pct) begin
			gaps = $urandom_range(4, 1);
		end
		repeat (gaps) begin
			@(posedge clk);
			#1;
		end
		waited = 0;
		while (stopin) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > STOPIN_LIMIT) begin
				fail_run("stopin stayed high, the core never took the full block");
			end
		end
		pushin  = 1'b1;
		firstin = first;
		din     = data;
		// stopin was low, so this edge accepts the beat
		@(posedge clk);
		#1;
		pushin  = 1'b0;
		firstin = 1'b0;
		din     = '0;
		model_accept(first, data, full);
		// loader is full right after its 25th lane and open otherwise
		check_level("stopin after beat", stopin, full);
	endtask

	// optional junk into an empty loader and a cut-short block first
	task automatic send_block(input logic junk, input logic restart);
		int n;
		int i;
		if (junk) begin
			n = $urandom_range(3, 1);
			for (i = 0; i < n; i++) begin
				send_beat(1'b0, rand_lane());
			end
		end
		if (restart) begin
			n = $urandom_range(23, 1);
			send_beat(1'b1, rand_lane());
			for (i = 0; i < n; i++) begin
				send_beat(1'b0, rand_lane());
			end
		end
		for (i = 0; i < `KECCAK_LANES; i++) begin
			send_beat(i == 0, rand_lane());
		end
	endtask

	task automatic drain_wait();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > DRAIN_LIMIT) begin
				fail_run("a sent block never came out as a complete result");
			end
		end
	endtask

	// stopout changes 1 ns after each rising edge
	task automatic drive_stopout();
		forever begin
			@(posedge clk);
			#1;
			stopout = (stall_pct > 0) && ($urandom_range(99) < stall_pct);
		end
	endtask

	// outputs are sampled mid-cycle and a beat moves at the next rising edge
	task automatic watch_output();
		forever begin
			@(negedge clk);
			if (held) begin
				check_level("pushout while stalled", pushout, 1'b1);
				check_lane("dout while stalled", dout, held_data);
				check_first("firstout while stalled", firstout, held_first);
			end
			held       = pushout & stopout;
			held_data  = dout;
			held_first = firstout;
			if (!pushout) begin
				check_first("firstout without pushout", firstout, 1'b0);
			end else if (!stopout) begin
				if (exp_q.size() == 0) begin
					fail_run("output beat arrived with no block outstanding");
				end
				cur = exp_q[0];
				check_first($sformatf("firstout lane %0d", out_pos), firstout, out_pos == 0);
				check_lane($sformatf("dout lane %0d", out_pos), dout,
					cur[out_pos / 5][out_pos % 5]);
				if (out_pos == 0) begin
					last_lane0 = dout;
				end
				out_pos++;
				if (out_pos == `KECCAK_LANES) begin
					void'(exp_q.pop_front());
					out_pos = 0;
				end
			end
		end
	endtask

	initial begin
		int i;
		rst         = 1'b1;
		pushin      = 1'b0;
		firstin     = 1'b0;
		din         = '0;
		stopout     = 1'b0;
		coll        = '0;
		coll_cnt    = 0;
		out_pos     = 0;
		stall_pct   = 0;
		gap_pct     = 0;
		held        = 1'b0;
		held_data   = '0;
		held_first  = 1'b0;
		last_lane0  = '0;
		void'($urandom(32'h71d3));
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle outputs straight out of reset
		check_level("stopin", stopin, 1'b0);
		check_level("pushout", pushout, 1'b0);
		check_first("firstout", firstout, 1'b0);
		check_lane("dout", dout, '0);
		fork
			watch_output();
			drive_stopout();
		join_none
		// all-zero block with a known first lane
		for (i = 0; i < `KECCAK_LANES; i++) begin
			send_beat(i == 0, '0);
		end
		drain_wait();
		check_lane("dout lane 0 of zero block", last_lane0, 64'hF1258F7940E1DDE7);
		// random blocks without back-pressure
		for (i = 0; i < 40; i++) begin
			send_block(1'b0, 1'b0);
		end
		drain_wait();
		// random stopout
		stall_pct = 40;
		for (i = 0; i < 20; i++) begin
			send_block(1'b0, 1'b0);
		end
		drain_wait();
		// input gaps, junk beats and restarts
		stall_pct = 25;
		gap_pct   = 30;
		for (i = 0; i < 20; i++) begin
			send_block($urandom_range(1) == 1, $urandom_range(1) == 1);
		end
		drain_wait();
		// heavy stalls back up into stopin
		stall_pct = 60;
		gap_pct   = 0;
		for (i = 0; i < 20; i++) begin
			send_block(1'b0, 1'b0);
		end
		drain_wait();
		stall_pct = 0;
		repeat (4) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 8 ns period, low for the first half
	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

endmodule
